//--- include/riscv_defines.svh
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// instruction memory is byte addressed
`define IMEM_AW 12

// data memory is word addressed
`define DMEM_AW 12

// first fetch after reset, sized to IMEM_AW
`define RESET_PC 12'h000

// ebreak: funct12 = 1, everything else zero except SYSTEM opcode
`define EBREAK_INSN 32'h0010_0073

`endif

//--- hw/riscv_pkg.sv
package riscv_pkg;

	// base opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_REG    = 7'b0110011,
		OP_IMM    = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_BRANCH = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL} branch_t;

	typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwd_sel_t;

	typedef enum logic {ST_RUN, ST_HALTED} core_state_t;

	// all zeros is a bubble
	typedef struct packed {
		logic    valid;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src_imm;
		alu_op_t alu_op;
		branch_t branch;
		logic    is_halt;
	} ctrl_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] pc;
		logic [31:0] rs1_val;
		logic [31:0] rs2_val;
		logic [31:0] imm;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] alu_result;
		logic [31:0] store_data;
		logic [4:0]  rd;
		logic [31:0] pc4;    // link value for jal
	} ex_mem_t;

	typedef struct packed {
		ctrl_t       ctrl;
		logic [31:0] wdata;
		logic [4:0]  rd;
	} mem_wb_t;

endpackage

//--- hw/riscv_control.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module riscv_control (
	input  logic [31:0]       insn,
	output riscv_pkg::ctrl_t  ctrl,
	output logic [31:0]       imm
);
	import riscv_pkg::*;

	opcode_t     opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_j;

	assign opcode = opcode_t'(insn[6:0]);
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	// immediates by format, all sign extended from bit 31
	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

	always_comb begin
		ctrl = '0;    // unknown encodings stay a bubble
		imm = '0;
		case (opcode)
			OP_REG: begin
				ctrl.reg_write = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
					{7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
					{7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
					{7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
					{7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
					default: ctrl.reg_write = 1'b0;
				endcase
				ctrl.valid = ctrl.reg_write;
			end
			OP_IMM: begin
				if (funct3 == 3'b000) begin    // addi only
					ctrl.valid = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					imm = imm_i;
				end
			end
			OP_LOAD: begin
				if (funct3 == 3'b010) begin
					ctrl.valid = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.mem_read = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					imm = imm_i;
				end
			end
			OP_STORE: begin
				if (funct3 == 3'b010) begin
					ctrl.valid = 1'b1;
					ctrl.mem_write = 1'b1;
					ctrl.alu_src_imm = 1'b1;
					imm = imm_s;
				end
			end
			OP_BRANCH: begin
				if (funct3 == 3'b000 || funct3 == 3'b001) begin
					ctrl.valid = 1'b1;
					ctrl.branch = (funct3 == 3'b000) ? BR_BEQ : BR_BNE;
					imm = imm_b;
				end
			end
			OP_JAL: begin
				ctrl.valid = 1'b1;
				ctrl.reg_write = 1'b1;    // rd gets pc+4
				ctrl.branch = BR_JAL;
				imm = imm_j;
			end
			OP_SYSTEM: begin
				if (insn == `EBREAK_INSN) begin
					ctrl.valid = 1'b1;
					ctrl.is_halt = 1'b1;
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		assert (!(ctrl.mem_read && ctrl.mem_write))
			else $error("control: load and store decoded together");
	end

endmodule

//--- hw/riscv_hazard_unit.sv
`timescale 1ns/100ps

module riscv_hazard_unit (
	input  logic [4:0]          id_rs1,
	input  logic [4:0]          id_rs2,
	input  riscv_pkg::id_ex_t   id_ex,
	input  riscv_pkg::ex_mem_t  ex_mem,
	input  riscv_pkg::mem_wb_t  mem_wb,
	output logic                stall,
	output riscv_pkg::fwd_sel_t fwd_a,
	output riscv_pkg::fwd_sel_t fwd_b
);
	import riscv_pkg::*;

	// youngest producer wins
	function automatic fwd_sel_t pick_source(input logic [4:0] rs);
		fwd_sel_t sel;
		sel = FWD_RF;
		if (mem_wb.ctrl.reg_write && mem_wb.rd != 5'd0 && mem_wb.rd == rs) begin
			sel = FWD_WB;
		end
		if (ex_mem.ctrl.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == rs) begin
			sel = FWD_MEM;
		end
		return sel;
	endfunction

	// selects for the instruction now in execute
	always_comb begin
		fwd_a = pick_source(id_ex.rs1);
		fwd_b = pick_source(id_ex.rs2);
	end

	// load in execute feeding the instruction in decode
	always_comb begin
		stall = 1'b0;
		if (id_ex.ctrl.mem_read && id_ex.rd != 5'd0) begin
			stall = (id_ex.rd == id_rs1) || (id_ex.rd == id_rs2);
		end
	end

	always_comb begin
		if (stall) begin
			assert (id_ex.ctrl != '0)
				else $error("hazard: stall raised behind a bubble");
		end
	end

endmodule

//--- hw/riscv_execute.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module riscv_execute (
	input  logic                  CLK,
	input  logic                  RSTn,
	input  riscv_pkg::id_ex_t     id_ex,
	input  riscv_pkg::fwd_sel_t   fwd_a,
	input  riscv_pkg::fwd_sel_t   fwd_b,
	input  logic [31:0]           mem_fwd,
	input  logic [31:0]           wb_fwd,
	output riscv_pkg::ex_mem_t    ex_mem,
	output logic                  redirect,
	output logic [`IMEM_AW-1:0]   redirect_pc
);
	import riscv_pkg::*;

	logic [31:0] op_a;
	logic [31:0] rs2_fwd;
	logic [31:0] op_b;
	logic [31:0] alu_y;
	logic [31:0] target;
	logic        taken;

	function automatic logic [31:0] fwd_mux(input fwd_sel_t sel, input logic [31:0] rf_val);
		logic [31:0] val;
		case (sel)
			FWD_MEM: val = mem_fwd;
			FWD_WB:  val = wb_fwd;
			default: val = rf_val;
		endcase
		return val;
	endfunction

	assign op_a = fwd_mux(fwd_a, id_ex.rs1_val);
	assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_val);    // also the store data
	assign op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			ALU_ADD:    alu_y = op_a + op_b;
			ALU_SUB:    alu_y = op_a - op_b;
			ALU_AND:    alu_y = op_a & op_b;
			ALU_OR:     alu_y = op_a | op_b;
			ALU_XOR:    alu_y = op_a ^ op_b;
			ALU_SLT:    alu_y = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_PASS_B: alu_y = op_b;
			default:    alu_y = op_a + op_b;
		endcase
	end

	// branch compare uses register operands, never the immediate
	always_comb begin
		case (id_ex.ctrl.branch)
			BR_BEQ:  taken = (op_a == rs2_fwd);
			BR_BNE:  taken = (op_a != rs2_fwd);
			BR_JAL:  taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign target = id_ex.pc + id_ex.imm;
	assign redirect = taken;
	assign redirect_pc = target[`IMEM_AW-1:0];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			ex_mem <= '0;
		end else begin
			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.alu_result <= alu_y;
			ex_mem.store_data <= rs2_fwd;
			ex_mem.rd <= id_ex.rd;
			ex_mem.pc4 <= id_ex.pc + 32'd4;
		end
	end

	// a bubble never carries a branch
	assert property (@(posedge CLK) disable iff (RSTn) redirect |-> id_ex.ctrl.valid)
		else $error("execute: redirect from a bubble");

	// top must flush the slot behind a taken branch
	assert property (@(posedge CLK) disable iff (RSTn) redirect |=> !redirect)
		else $error("execute: redirect on two cycles in a row");

endmodule

//--- hw/riscv_fetch.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module riscv_fetch (
	input  logic                CLK,
	input  logic                RSTn,
	input  logic                stall,
	input  logic                redirect,
	input  logic [`IMEM_AW-1:0] redirect_pc,
	input  logic                halted,
	output logic [`IMEM_AW-1:0] pc
);

	logic [`IMEM_AW-1:0] pc_next;

	// redirect beats stall, hold on stall or halt
	always_comb begin
		if (redirect) begin
			pc_next = redirect_pc;
		end else if (stall || halted) begin
			pc_next = pc;
		end else begin
			pc_next = pc + `IMEM_AW'(4);
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// targets come from execute, keep them word aligned
	assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00)
		else $error("fetch: misaligned pc %h", pc);

endmodule

//--- hw/riscv_top.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module riscv_top (
	input  logic                CLK,
	input  logic                RSTn,
	// instruction memory
	output logic                I_MEM_CSN,
	output logic [`IMEM_AW-1:0] I_MEM_ADDR,    // byte address
	input  logic [31:0]         I_MEM_DI,
	// data memory
	output logic                D_MEM_CSN,
	output logic [`DMEM_AW-1:0] D_MEM_ADDR,    // word address
	output logic [31:0]         D_MEM_DOUT,
	output logic                D_MEM_WEN,     // active low
	input  logic [31:0]         D_MEM_DI,
	// register file
	output logic                RF_WE,
	output logic [4:0]          RF_RA1,
	output logic [4:0]          RF_RA2,
	output logic [4:0]          RF_WA1,
	output logic [31:0]         RF_WD,
	input  logic [31:0]         RF_RD1,
	input  logic [31:0]         RF_RD2,
	output logic                HALT,
	output logic [31:0]         NUM_INST
);
	import riscv_pkg::*;

	logic [`IMEM_AW-1:0] pc;
	logic [31:0]         ifid_insn;    // zero decodes as a bubble
	logic [31:0]         ifid_pc;
	ctrl_t               id_ctrl;
	logic [31:0]         id_imm;
	id_ex_t              id_ex;
	ex_mem_t             ex_mem;
	mem_wb_t             mem_wb;
	logic                stall;
	logic                redirect;
	logic [`IMEM_AW-1:0] redirect_pc;
	fwd_sel_t            fwd_a;
	fwd_sel_t            fwd_b;
	logic [31:0]         mem_result;
	logic                squash;
	core_state_t         state;

	// ebreak in execute or later, nothing younger may proceed
	assign squash = id_ex.ctrl.is_halt || ex_mem.ctrl.is_halt || mem_wb.ctrl.is_halt ||
		(state == ST_HALTED);

	riscv_fetch u_fetch (
		.CLK(CLK), .RSTn(RSTn), .stall(stall), .redirect(redirect),
		.redirect_pc(redirect_pc), .halted(squash), .pc(pc)
	);

	assign I_MEM_ADDR = pc;
	assign I_MEM_CSN = (state == ST_HALTED);

	always_ff @(posedge CLK) begin
		if (RSTn || redirect || squash) begin
			ifid_insn <= '0;
		end else if (!stall) begin
			ifid_insn <= I_MEM_DI;
		end
		if (!stall) begin
			ifid_pc <= {{(32 - `IMEM_AW){1'b0}}, pc};
		end
	end

	// decode
	assign RF_RA1 = ifid_insn[19:15];
	assign RF_RA2 = ifid_insn[24:20];

	riscv_control u_control (.insn(ifid_insn), .ctrl(id_ctrl), .imm(id_imm));

	riscv_hazard_unit u_hazard (
		.id_rs1(RF_RA1), .id_rs2(RF_RA2), .id_ex(id_ex), .ex_mem(ex_mem),
		.mem_wb(mem_wb), .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	always_ff @(posedge CLK) begin
		id_ex.pc <= ifid_pc;
		id_ex.rs1_val <= RF_RD1;    // write-first rf covers the wb slot
		id_ex.rs2_val <= RF_RD2;
		id_ex.imm <= id_imm;
		id_ex.rs1 <= ifid_insn[19:15];
		id_ex.rs2 <= ifid_insn[24:20];
		id_ex.rd <= ifid_insn[11:7];
		if (RSTn || redirect || stall || squash) begin
			id_ex.ctrl <= '0;
		end else begin
			id_ex.ctrl <= id_ctrl;
		end
	end

	riscv_execute u_execute (
		.CLK(CLK), .RSTn(RSTn), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.mem_fwd(mem_result), .wb_fwd(mem_wb.wdata), .ex_mem(ex_mem),
		.redirect(redirect), .redirect_pc(redirect_pc)
	);

	// memory stage
	assign mem_result = (ex_mem.ctrl.branch == BR_JAL) ? ex_mem.pc4 : ex_mem.alu_result;
	assign D_MEM_CSN = (state == ST_HALTED);
	assign D_MEM_ADDR = ex_mem.alu_result[`DMEM_AW+1:2];
	assign D_MEM_DOUT = ex_mem.store_data;
	assign D_MEM_WEN = !(ex_mem.ctrl.mem_write && state == ST_RUN);

	always_ff @(posedge CLK) begin
		mem_wb.wdata <= ex_mem.ctrl.mem_read ? D_MEM_DI : mem_result;
		mem_wb.rd <= ex_mem.rd;
		if (RSTn) begin
			mem_wb.ctrl <= '0;
		end else begin
			mem_wb.ctrl <= ex_mem.ctrl;
		end
	end

	// writeback
	assign RF_WE = mem_wb.ctrl.reg_write && (state == ST_RUN);
	assign RF_WA1 = mem_wb.rd;
	assign RF_WD = mem_wb.wdata;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			state <= ST_RUN;
			NUM_INST <= '0;
		end else if (state == ST_RUN && mem_wb.ctrl.valid) begin
			NUM_INST <= NUM_INST + 32'd1;    // ebreak counts too
			if (mem_wb.ctrl.is_halt) begin
				state <= ST_HALTED;
			end
		end
	end

	assign HALT = (state == ST_HALTED);

endmodule

//--- verification/riscv_tb_mem.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module riscv_tb_mem (
	input  logic                CLK,
	input  logic                init,         // clears imem and rf, fills dmem
	input  logic                load_en,
	input  logic [`IMEM_AW-3:0] load_addr,    // word index
	input  logic [31:0]         load_data,
	input  logic                imem_csn,
	input  logic [`IMEM_AW-1:0] imem_addr,
	output logic [31:0]         imem_rdata,
	input  logic                dmem_csn,
	input  logic [`DMEM_AW-1:0] dmem_addr,
	input  logic [31:0]         dmem_wdata,
	input  logic                dmem_wen,
	output logic [31:0]         dmem_rdata,
	input  logic                rf_we,
	input  logic [4:0]          rf_ra1,
	input  logic [4:0]          rf_ra2,
	input  logic [4:0]          rf_wa,
	input  logic [31:0]         rf_wd,
	output logic [31:0]         rf_rd1,
	output logic [31:0]         rf_rd2
);

	logic [31:0] imem [0:(1 << (`IMEM_AW - 2)) - 1];
	logic [31:0] dmem [0:(1 << `DMEM_AW) - 1];
	logic [31:0] rf [0:31];
	integer      k;

	always @(posedge CLK) begin
		if (init) begin
			imem <= '{default: '0};    // zero words decode as bubbles
			rf <= '{default: '0};
			for (k = 0; k < (1 << `DMEM_AW); k = k + 1) begin
				dmem[k[`DMEM_AW-1:0]] <= {16'hd00d, 16'(k)};
			end
		end else begin
			if (load_en) begin
				imem[load_addr] <= load_data;
			end
			if (!dmem_csn && !dmem_wen) begin
				dmem[dmem_addr] <= dmem_wdata;
			end
			if (rf_we && rf_wa != 5'd0) begin
				rf[rf_wa] <= rf_wd;
			end
		end
	end

	assign imem_rdata = imem_csn ? 32'd0 : imem[imem_addr[`IMEM_AW-1:2]];
	assign dmem_rdata = dmem_csn ? 32'd0 : dmem[dmem_addr];

	// write-first, x0 hardwired
	assign rf_rd1 = (rf_ra1 == 5'd0) ? 32'd0 : (rf_we && rf_wa == rf_ra1) ? rf_wd : rf[rf_ra1];
	assign rf_rd2 = (rf_ra2 == 5'd0) ? 32'd0 : (rf_we && rf_wa == rf_ra2) ? rf_wd : rf[rf_ra2];

endmodule

//--- verification/riscv_tb.sv
`timescale 1ns/100ps
`include "riscv_defines.svh"

module riscv_tb;

	localparam logic [31:0] EBREAK = 32'h0010_0073;

	logic                CLK;
	logic                RSTn;
	logic                init;
	logic                load_en;
	logic [`IMEM_AW-3:0] load_addr;
	logic [31:0]         load_data;
	logic                I_MEM_CSN;
	logic [`IMEM_AW-1:0] I_MEM_ADDR;
	logic [31:0]         I_MEM_DI;
	logic                D_MEM_CSN;
	logic [`DMEM_AW-1:0] D_MEM_ADDR;
	logic [31:0]         D_MEM_DOUT;
	logic                D_MEM_WEN;
	logic [31:0]         D_MEM_DI;
	logic                RF_WE;
	logic [4:0]          RF_RA1;
	logic [4:0]          RF_RA2;
	logic [4:0]          RF_WA1;
	logic [31:0]         RF_WD;
	logic [31:0]         RF_RD1;
	logic [31:0]         RF_RD2;
	logic                HALT;
	logic [31:0]         NUM_INST;
	logic [31:0]         shadow [0:31];    // architectural register view
	logic [31:0]         written;          // registers written since reset
	logic [31:0]         prog [$];
	int                  seed = 32'h4aef_db28;
	int                  errors = 0;
	int                  monitor_errors = 0;

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	riscv_top DUT (.*);

	riscv_tb_mem mem_model (
		.CLK(CLK), .init(init), .load_en(load_en), .load_addr(load_addr),
		.load_data(load_data), .imem_csn(I_MEM_CSN), .imem_addr(I_MEM_ADDR),
		.imem_rdata(I_MEM_DI), .dmem_csn(D_MEM_CSN), .dmem_addr(D_MEM_ADDR),
		.dmem_wdata(D_MEM_DOUT), .dmem_wen(D_MEM_WEN), .dmem_rdata(D_MEM_DI),
		.rf_we(RF_WE), .rf_ra1(RF_RA1), .rf_ra2(RF_RA2), .rf_wa(RF_WA1),
		.rf_wd(RF_WD), .rf_rd1(RF_RD1), .rf_rd2(RF_RD2)
	);

	always @(posedge CLK) begin
		if (RSTn) begin
			shadow <= '{default: '0};
			written <= '0;
		end else begin
			if (RF_WE && RF_WA1 != 5'd0) begin
				shadow[RF_WA1] <= RF_WD;
				written[RF_WA1] <= 1'b1;
			end
			if (HALT && (RF_WE || !D_MEM_WEN)) begin
				monitor_errors <= monitor_errors + 1;
				$display("register or memory write after HALT at %0t", $time);
			end
		end
	end

	function automatic logic [31:0] addi_insn(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic logic [31:0] load_insn(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic logic [31:0] store_insn(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] rtype_insn(input int f7, input int f3, input int rd,
		input int rs1, input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	// f3 0 is beq, 1 is bne
	function automatic logic [31:0] branch_insn(input int f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jal_insn(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic compare_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_reg(input int r, input logic [31:0] exp);
		compare_word($sformatf("x%0d", r), shadow[r[4:0]], exp);
	endtask

	// load prog, reset, run to HALT and check the retire count
	task automatic run_program(input logic [31:0] exp_count);
		int i;
		int cycles;
		@(posedge CLK);
		RSTn <= 1'b1;
		init <= 1'b1;
		@(posedge CLK);
		init <= 1'b0;
		for (i = 0; i < prog.size(); i++) begin
			load_en <= 1'b1;
			load_addr <= (`IMEM_AW-2)'(i);
			load_data <= prog[i];
			@(posedge CLK);
		end
		load_en <= 1'b0;
		repeat (4) @(posedge CLK);
		RSTn <= 1'b0;
		@(negedge CLK);
		compare_word("HALT", {31'b0, HALT}, 32'd0);
		compare_word("NUM_INST", NUM_INST, 32'd0);
		compare_word("D_MEM_WEN", {31'b0, D_MEM_WEN}, 32'd1);
		compare_word("RF_WE", {31'b0, RF_WE}, 32'd0);
		compare_word("I_MEM_CSN", {31'b0, I_MEM_CSN}, 32'd0);
		compare_word("D_MEM_CSN", {31'b0, D_MEM_CSN}, 32'd0);
		cycles = 0;
		while (HALT !== 1'b1 && cycles < 500) begin
			@(negedge CLK);
			cycles++;
		end
		if (HALT !== 1'b1) begin
			$display("timeout: HALT did not rise within 500 cycles");
			$display("Result: FAILED");
			$finish;
		end
		compare_word("NUM_INST", NUM_INST, exp_count);
		repeat (10) begin
			@(negedge CLK);
			if (HALT !== 1'b1) begin
				errors++;
				$display("HALT dropped without reset at %0t", $time);
			end
		end
		compare_word("NUM_INST", NUM_INST, exp_count);    // frozen after halt
	endtask

	task automatic alu_ops_test();
		int ia;
		int ib;
		int ic;
		logic [31:0] a;
		logic [31:0] b;
		ia = $random(seed);
		ib = $random(seed);
		ic = $random(seed);
		a = {{20{ia[11]}}, ia[11:0]};
		b = {{20{ib[11]}}, ib[11:0]};
		prog.delete();
		prog.push_back(addi_insn(1, 0, ia));
		prog.push_back(addi_insn(2, 0, ib));
		prog.push_back(rtype_insn(7'h00, 0, 3, 1, 2));    // add
		prog.push_back(rtype_insn(7'h20, 0, 4, 1, 2));    // sub
		prog.push_back(rtype_insn(7'h00, 7, 5, 1, 2));
		prog.push_back(rtype_insn(7'h00, 6, 6, 1, 2));
		prog.push_back(rtype_insn(7'h00, 4, 7, 1, 2));
		prog.push_back(rtype_insn(7'h00, 2, 8, 1, 2));    // slt both ways
		prog.push_back(rtype_insn(7'h00, 2, 9, 2, 1));
		prog.push_back(addi_insn(10, 1, ic));
		prog.push_back(rtype_insn(7'h00, 0, 0, 1, 2));    // write to x0
		prog.push_back(rtype_insn(7'h00, 0, 11, 0, 1));   // x0 must still read zero
		prog.push_back(EBREAK);
		run_program(32'd13);
		compare_reg(1, a);
		compare_reg(2, b);
		compare_reg(3, a + b);
		compare_reg(4, a - b);
		compare_reg(5, a & b);
		compare_reg(6, a | b);
		compare_reg(7, a ^ b);
		compare_reg(8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		compare_reg(9, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		compare_reg(10, a + {{20{ic[11]}}, ic[11:0]});
		compare_reg(11, a);
	endtask

	// consumers at distance one, two, three and four
	task automatic forwarding_test();
		int ia;
		int ib;
		logic [31:0] a;
		logic [31:0] b;
		ia = $random(seed);
		ib = $random(seed);
		a = {{20{ia[11]}}, ia[11:0]};
		b = {{20{ib[11]}}, ib[11:0]};
		prog.delete();
		prog.push_back(addi_insn(1, 0, ia));
		prog.push_back(addi_insn(2, 1, ib));
		prog.push_back(addi_insn(5, 0, 7));
		prog.push_back(rtype_insn(7'h00, 0, 3, 1, 2));
		prog.push_back(rtype_insn(7'h20, 0, 4, 3, 1));
		prog.push_back(addi_insn(6, 0, 1));
		prog.push_back(addi_insn(7, 0, 2));
		prog.push_back(rtype_insn(7'h00, 4, 8, 4, 3));
		prog.push_back(EBREAK);
		run_program(32'd9);
		compare_reg(1, a);
		compare_reg(2, a + b);
		compare_reg(3, a + a + b);
		compare_reg(4, a + b);
		compare_reg(8, (a + b) ^ (a + a + b));
	endtask

	task automatic load_store_test();
		int ia;
		logic [31:0] a;
		ia = $random(seed);
		a = {{20{ia[11]}}, ia[11:0]};
		prog.delete();
		prog.push_back(addi_insn(1, 0, ia));
		prog.push_back(addi_insn(2, 0, 12'h100));
		prog.push_back(store_insn(1, 2, 8));      // word 0x42
		prog.push_back(load_insn(3, 2, 8));
		prog.push_back(rtype_insn(7'h00, 0, 4, 3, 3));    // load-use
		prog.push_back(load_insn(5, 2, 12));      // untouched word 0x43
		prog.push_back(addi_insn(6, 5, 1));
		prog.push_back(EBREAK);
		run_program(32'd8);
		compare_reg(3, a);
		compare_reg(4, a + a);
		compare_reg(5, 32'hd00d_0043);
		compare_reg(6, 32'hd00d_0044);
		compare_word("dmem[0x042]", mem_model.dmem[12'h042], a);
	endtask

	// x20 to x24 sit only in slots that a taken branch or jal discards
	task automatic branch_test();
		prog.delete();
		prog.push_back(addi_insn(1, 0, 5));
		prog.push_back(addi_insn(2, 0, 5));
		prog.push_back(branch_insn(0, 1, 2, 12));    // beq taken, 8 to 20
		prog.push_back(addi_insn(20, 0, 1));
		prog.push_back(addi_insn(21, 0, 1));
		prog.push_back(branch_insn(1, 1, 2, 8));     // bne not taken
		prog.push_back(addi_insn(3, 0, 3));
		prog.push_back(jal_insn(4, 12));             // 28 to 40
		prog.push_back(addi_insn(22, 0, 1));
		prog.push_back(addi_insn(23, 0, 1));
		prog.push_back(branch_insn(0, 1, 0, 8));     // beq not taken
		prog.push_back(branch_insn(1, 3, 0, 8));     // bne taken, 44 to 52
		prog.push_back(addi_insn(24, 0, 1));
		prog.push_back(EBREAK);
		run_program(32'd9);
		compare_reg(1, 32'd5);
		compare_reg(2, 32'd5);
		compare_reg(3, 32'd3);
		compare_reg(4, 32'd32);    // link is pc+4
		if (written[24:20] != 5'b0) begin
			errors++;
			$display("a flushed instruction wrote a register at %0t", $time);
		end
	endtask

	initial begin
		RSTn <= 1'b1;
		init <= 1'b0;
		load_en <= 1'b0;
		load_addr <= '0;
		load_data <= '0;
		repeat (3) alu_ops_test();
		forwarding_test();
		load_store_test();
		branch_test();
		@(negedge CLK);
		$display("check errors: %0d, monitor errors: %0d", errors, monitor_errors);
		if (errors == 0 && monitor_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- riscv_pipe.f
+incdir+include
hw/riscv_pkg.sv
hw/riscv_control.sv
hw/riscv_hazard_unit.sv
hw/riscv_execute.sv
hw/riscv_fetch.sv
hw/riscv_top.sv
verification/riscv_tb_mem.sv
verification/riscv_tb.sv

//--- run_sim.sh
#!/bin/bash
# builds the pipeline testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module riscv_tb \
	-f riscv_pipe.f > build.log 2>&1 &&
	./obj_dir/Vriscv_tb > sim.log 2>&1 &&
	! grep -q "Result: FAILED" sim.log &&
	echo "simulation passed" ||
	{ echo "simulation failed, see build.log and sim.log"; exit 1; }
